//--- verilog/axi_conv_pkg.sv
// Width typedefs, response codes and full/Lite AXI channel structs
`default_nettype none

package axi_conv_pkg;

  // Field widths of the 32-bit bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Full AXI4 channels, single beat only
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    prot_t prot;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } axi_b_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    prot_t prot;
  } axi_ar_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } axi_r_t;

  // AXI4-Lite channels
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_t;

  typedef struct packed {
    resp_t resp;
  } lite_b_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_ar_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } lite_r_t;

endpackage

`default_nettype wire

//--- verilog/id_reflect_fifo.sv
// Synchronous ID FIFO with full and empty flags
`default_nettype none

module id_reflect_fifo
  import axi_conv_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  logic pop_i,
  input  id_t  data_i,
  output id_t  data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  localparam ptr_t LAST_PTR  = ptr_t'(DEPTH - 1);
  localparam cnt_t FULL_CNT  = cnt_t'(DEPTH);

  id_t  mem_q [DEPTH];
  ptr_t rd_ptr_q;
  ptr_t wr_ptr_q;
  cnt_t count_q;
  logic push_ok;
  logic pop_ok;

  assign full_o  = (count_q == FULL_CNT);
  assign empty_o = (count_q == '0);

  // Requests that cannot be served are dropped
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count only moves when exactly one side acts
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_write_reflect.sv
// Full AXI4 to AXI4-Lite write converter with B ID reflection
`default_nettype none

module axi_write_reflect
  import axi_conv_pkg::*;
#(
  parameter int unsigned MAX_WRITE_TXNS = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Full AXI slave side
  input  axi_aw_t  s_aw_i,
  input  logic     s_aw_valid_i,
  output logic     s_aw_ready_o,
  input  axi_w_t   s_w_i,
  input  logic     s_w_valid_i,
  output logic     s_w_ready_o,
  output axi_b_t   s_b_o,
  output logic     s_b_valid_o,
  input  logic     s_b_ready_i,
  // Lite master side
  output lite_aw_t m_aw_o,
  output logic     m_aw_valid_o,
  input  logic     m_aw_ready_i,
  output lite_w_t  m_w_o,
  output logic     m_w_valid_o,
  input  logic     m_w_ready_i,
  input  lite_b_t  m_b_i,
  input  logic     m_b_valid_i,
  output logic     m_b_ready_o
);

  logic id_full;
  logic id_empty;
  logic id_push;
  logic id_pop;
  id_t  b_id;

  // AW is cropped and held back while no ID slot is free
  assign m_aw_o       = '{addr: s_aw_i.addr, prot: s_aw_i.prot};
  assign m_aw_valid_o = s_aw_valid_i & ~id_full;
  assign s_aw_ready_o = m_aw_ready_i & ~id_full;

  // W only loses the last flag
  assign m_w_o       = '{data: s_w_i.data, strb: s_w_i.strb};
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  // B passes only while a stored ID is waiting for it
  assign s_b_o       = '{id: b_id, resp: m_b_i.resp};
  assign s_b_valid_o = m_b_valid_i & ~id_empty;
  assign m_b_ready_o = s_b_ready_i & ~id_empty;

  assign id_push = m_aw_valid_o & s_aw_ready_o;
  assign id_pop  = s_b_valid_o & s_b_ready_i;

  id_reflect_fifo #(
    .DEPTH   ( MAX_WRITE_TXNS )
  ) i_aw_id_fifo (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .push_i  ( id_push        ),
    .pop_i   ( id_pop         ),
    .data_i  ( s_aw_i.id      ),
    .data_o  ( b_id           ),
    .full_o  ( id_full        ),
    .empty_o ( id_empty       )
  );

endmodule

`default_nettype wire

//--- verilog/axi_read_reflect.sv
// Full AXI4 to AXI4-Lite read converter with R ID reflection
`default_nettype none

module axi_read_reflect
  import axi_conv_pkg::*;
#(
  parameter int unsigned MAX_READ_TXNS = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Full AXI slave side
  input  axi_ar_t  s_ar_i,
  input  logic     s_ar_valid_i,
  output logic     s_ar_ready_o,
  output axi_r_t   s_r_o,
  output logic     s_r_valid_o,
  input  logic     s_r_ready_i,
  // Lite master side
  output lite_ar_t m_ar_o,
  output logic     m_ar_valid_o,
  input  logic     m_ar_ready_i,
  input  lite_r_t  m_r_i,
  input  logic     m_r_valid_i,
  output logic     m_r_ready_o
);

  logic id_full;
  logic id_empty;
  logic id_push;
  logic id_pop;
  id_t  r_id;

  assign m_ar_o       = '{addr: s_ar_i.addr, prot: s_ar_i.prot};
  assign m_ar_valid_o = s_ar_valid_i & ~id_full;
  assign s_ar_ready_o = m_ar_ready_i & ~id_full;

  // Every read is a single beat, so last is constant
  assign s_r_o = '{
    id:   r_id,
    data: m_r_i.data,
    resp: m_r_i.resp,
    last: 1'b1
  };
  assign s_r_valid_o = m_r_valid_i & ~id_empty;
  assign m_r_ready_o = s_r_ready_i & ~id_empty;

  assign id_push = m_ar_valid_o & s_ar_ready_o;
  assign id_pop  = s_r_valid_o & s_r_ready_i;

  id_reflect_fifo #(
    .DEPTH   ( MAX_READ_TXNS )
  ) i_ar_id_fifo (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .push_i  ( id_push       ),
    .pop_i   ( id_pop        ),
    .data_i  ( s_ar_i.id     ),
    .data_o  ( r_id          ),
    .full_o  ( id_full       ),
    .empty_o ( id_empty      )
  );

endmodule

`default_nettype wire

//--- verilog/lite_reg_bank.sv
// AXI4-Lite register bank with byte strobes and SLVERR outside the map
`default_nettype none

module lite_reg_bank
  import axi_conv_pkg::*;
#(
  parameter int unsigned NUM_REGS = 8
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Write channels
  input  lite_aw_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  lite_w_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output lite_b_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  // Read channels
  input  lite_ar_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output lite_r_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i
);

  localparam int unsigned IDX_W   = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  localparam int unsigned LANES   = $bits(strb_t);

  typedef logic [IDX_W-1:0] idx_t;

  data_t regs_q [NUM_REGS];

  logic        wr_accept;
  logic        rd_accept;
  logic [29:0] wr_word;
  logic [29:0] rd_word;
  logic        wr_in_range;
  logic        rd_in_range;
  idx_t        wr_idx;
  idx_t        rd_idx;
  logic        b_pending_q;
  logic        r_pending_q;
  resp_t       b_resp_q;
  data_t       r_data_q;
  resp_t       r_resp_q;

  // Word index, byte offset bits dropped
  assign wr_word     = aw_i.addr[31:2];
  assign rd_word     = ar_i.addr[31:2];
  assign wr_in_range = (wr_word < NUM_REGS);
  assign rd_in_range = (rd_word < NUM_REGS);
  assign wr_idx      = wr_word[IDX_W-1:0];
  assign rd_idx      = rd_word[IDX_W-1:0];

  // AW and W are taken together, one B outstanding at most
  assign wr_accept  = aw_valid_i & w_valid_i & ~b_pending_q;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  assign ar_ready_o = ~r_pending_q;
  assign rd_accept  = ar_valid_i & ~r_pending_q;

  assign b_valid_o = b_pending_q;
  assign b_o       = '{resp: b_resp_q};
  assign r_valid_o = r_pending_q;
  assign r_o       = '{data: r_data_q, resp: r_resp_q};

  // Register array with per-byte write enables
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_accept && wr_in_range) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (w_i.strb[lane]) begin
          regs_q[wr_idx][8*lane +: 8] <= w_i.data[8*lane +: 8];
        end
      end
    end
  end

  // Response flags
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_pending_q <= 1'b0;
      r_pending_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        b_pending_q <= 1'b1;
      end else if (b_ready_i) begin
        b_pending_q <= 1'b0;
      end
      if (rd_accept) begin
        r_pending_q <= 1'b1;
      end else if (r_ready_i) begin
        r_pending_q <= 1'b0;
      end
    end
  end

  // Response payloads, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_accept) begin
      r_data_q <= rd_in_range ? regs_q[rd_idx] : '0;
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_to_lite_top.sv
// Top level with write and read converters feeding a Lite register bank
`default_nettype none

module axi_to_lite_top
  import axi_conv_pkg::*;
#(
  parameter int unsigned MAX_WRITE_TXNS = 4,
  parameter int unsigned MAX_READ_TXNS  = 4,
  parameter int unsigned NUM_REGS       = 8
) (
  input  logic    clk_i,
  input  logic    rst_i,
  // Full AXI4 slave port
  input  axi_aw_t s_aw_i,
  input  logic    s_aw_valid_i,
  output logic    s_aw_ready_o,
  input  axi_w_t  s_w_i,
  input  logic    s_w_valid_i,
  output logic    s_w_ready_o,
  output axi_b_t  s_b_o,
  output logic    s_b_valid_o,
  input  logic    s_b_ready_i,
  input  axi_ar_t s_ar_i,
  input  logic    s_ar_valid_i,
  output logic    s_ar_ready_o,
  output axi_r_t  s_r_o,
  output logic    s_r_valid_o,
  input  logic    s_r_ready_i
);

  // Lite bus between converters and bank
  lite_aw_t lite_aw;
  logic     lite_aw_valid;
  logic     lite_aw_ready;
  lite_w_t  lite_w;
  logic     lite_w_valid;
  logic     lite_w_ready;
  lite_b_t  lite_b;
  logic     lite_b_valid;
  logic     lite_b_ready;
  lite_ar_t lite_ar;
  logic     lite_ar_valid;
  logic     lite_ar_ready;
  lite_r_t  lite_r;
  logic     lite_r_valid;
  logic     lite_r_ready;

  axi_write_reflect #(
    .MAX_WRITE_TXNS ( MAX_WRITE_TXNS )
  ) i_write_reflect (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .s_aw_i       ( s_aw_i        ),
    .s_aw_valid_i ( s_aw_valid_i  ),
    .s_aw_ready_o ( s_aw_ready_o  ),
    .s_w_i        ( s_w_i         ),
    .s_w_valid_i  ( s_w_valid_i   ),
    .s_w_ready_o  ( s_w_ready_o   ),
    .s_b_o        ( s_b_o         ),
    .s_b_valid_o  ( s_b_valid_o   ),
    .s_b_ready_i  ( s_b_ready_i   ),
    .m_aw_o       ( lite_aw       ),
    .m_aw_valid_o ( lite_aw_valid ),
    .m_aw_ready_i ( lite_aw_ready ),
    .m_w_o        ( lite_w        ),
    .m_w_valid_o  ( lite_w_valid  ),
    .m_w_ready_i  ( lite_w_ready  ),
    .m_b_i        ( lite_b        ),
    .m_b_valid_i  ( lite_b_valid  ),
    .m_b_ready_o  ( lite_b_ready  )
  );

  axi_read_reflect #(
    .MAX_READ_TXNS ( MAX_READ_TXNS )
  ) i_read_reflect (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .s_ar_i       ( s_ar_i        ),
    .s_ar_valid_i ( s_ar_valid_i  ),
    .s_ar_ready_o ( s_ar_ready_o  ),
    .s_r_o        ( s_r_o         ),
    .s_r_valid_o  ( s_r_valid_o   ),
    .s_r_ready_i  ( s_r_ready_i   ),
    .m_ar_o       ( lite_ar       ),
    .m_ar_valid_o ( lite_ar_valid ),
    .m_ar_ready_i ( lite_ar_ready ),
    .m_r_i        ( lite_r        ),
    .m_r_valid_i  ( lite_r_valid  ),
    .m_r_ready_o  ( lite_r_ready  )
  );

  lite_reg_bank #(
    .NUM_REGS ( NUM_REGS )
  ) i_reg_bank (
    .clk_i      ( clk_i         ),
    .rst_i      ( rst_i         ),
    .aw_i       ( lite_aw       ),
    .aw_valid_i ( lite_aw_valid ),
    .aw_ready_o ( lite_aw_ready ),
    .w_i        ( lite_w        ),
    .w_valid_i  ( lite_w_valid  ),
    .w_ready_o  ( lite_w_ready  ),
    .b_o        ( lite_b        ),
    .b_valid_o  ( lite_b_valid  ),
    .b_ready_i  ( lite_b_ready  ),
    .ar_i       ( lite_ar       ),
    .ar_valid_i ( lite_ar_valid ),
    .ar_ready_o ( lite_ar_ready ),
    .r_o        ( lite_r        ),
    .r_valid_o  ( lite_r_valid  ),
    .r_ready_i  ( lite_r_ready  )
  );

endmodule

`default_nettype wire

//--- test/axi_to_lite_tb.sv
// Directed testbench for the AXI4 to AXI4-Lite converter with ID reflection
`default_nettype none

module axi_to_lite_tb
  import axi_conv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGS    = 8;
  localparam int WAIT_LIMIT  = 20;
  localparam int CYCLE_LIMIT = 4000;
  localparam int RAND_TXNS   = 150;

  // Handshake conditions that wait_high can watch
  localparam int WR_ACCEPT = 0;
  localparam int B_VALID   = 1;
  localparam int AR_ACCEPT = 2;
  localparam int R_VALID   = 3;

  logic    clk_i;
  logic    rst_i;
  axi_aw_t s_aw_i;
  logic    s_aw_valid_i;
  logic    s_aw_ready_o;
  axi_w_t  s_w_i;
  logic    s_w_valid_i;
  logic    s_w_ready_o;
  axi_b_t  s_b_o;
  logic    s_b_valid_o;
  logic    s_b_ready_i;
  axi_ar_t s_ar_i;
  logic    s_ar_valid_i;
  logic    s_ar_ready_o;
  axi_r_t  s_r_o;
  logic    s_r_valid_o;
  logic    s_r_ready_i;

  int          errors = 0;
  int unsigned cycles = 0;
  logic [31:0] lfsr_q = 32'd98502;
  data_t       ref_regs [NUM_REGS];

  axi_to_lite_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Global watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("ERROR: simulation still running after %0d cycles, stopped", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_q[0];
      lfsr_q  = lfsr_q >> 1;
      if (out_bit) begin
        lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  function automatic logic in_map(input addr_t addr);
    return (addr[31:2] < NUM_REGS);
  endfunction

  // Reference model of the register map
  function automatic void model_write(input addr_t addr, input data_t data, input strb_t strb);
    int idx;
    if (!in_map(addr)) begin
      return;
    end
    idx = int'(addr[31:2]);
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        ref_regs[idx][8*lane +: 8] = data[8*lane +: 8];
      end
    end
  endfunction

  function automatic data_t model_read(input addr_t addr);
    if (!in_map(addr)) begin
      return '0;
    end
    return ref_regs[int'(addr[31:2])];
  endfunction

  function automatic resp_t model_resp(input addr_t addr);
    return in_map(addr) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      WR_ACCEPT: return s_aw_ready_o && s_w_ready_o;
      B_VALID:   return s_b_valid_o;
      AR_ACCEPT: return s_ar_ready_o;
      default:   return s_r_valid_o;
    endcase
  endfunction

  // Returns at the falling edge where the condition holds
  task automatic wait_high(input int sel, input string what, output int waited);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!probe(sel) && waited < WAIT_LIMIT);
    if (!probe(sel)) begin
      $display("ERROR: %s did not happen within %0d cycles", what, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic drive_write(input id_t id, input addr_t addr, input data_t data,
                             input strb_t strb);
    s_aw_i       <= '{id: id, addr: addr, len: '0, prot: '0};
    s_aw_valid_i <= 1'b1;
    s_w_i        <= '{data: data, strb: strb, last: 1'b1};
    s_w_valid_i  <= 1'b1;
  endtask

  task automatic axi_write(input id_t id, input addr_t addr, input data_t data,
                           input strb_t strb, output axi_b_t b);
    int waited;
    @(posedge clk_i);
    drive_write(id, addr, data, strb);
    wait_high(WR_ACCEPT, "write acceptance", waited);
    @(posedge clk_i);
    s_aw_valid_i <= 1'b0;
    s_w_valid_i  <= 1'b0;
    s_b_ready_i  <= 1'b1;
    wait_high(B_VALID, "write response", waited);
    check_value("b latency", 1, waited);
    b = s_b_o;
    @(posedge clk_i);
    s_b_ready_i <= 1'b0;
  endtask

  task automatic axi_read(input id_t id, input addr_t addr, output axi_r_t r);
    int waited;
    @(posedge clk_i);
    s_ar_i       <= '{id: id, addr: addr, len: '0, prot: '0};
    s_ar_valid_i <= 1'b1;
    wait_high(AR_ACCEPT, "read acceptance", waited);
    @(posedge clk_i);
    s_ar_valid_i <= 1'b0;
    s_r_ready_i  <= 1'b1;
    wait_high(R_VALID, "read response", waited);
    check_value("r latency", 1, waited);
    r = s_r_o;
    @(posedge clk_i);
    s_r_ready_i <= 1'b0;
  endtask

  task automatic write_check(input string name, input id_t id, input addr_t addr,
                             input data_t data, input strb_t strb);
    axi_b_t b;
    axi_write(id, addr, data, strb, b);
    check_value({name, " b.id"}, id, b.id);
    check_value({name, " b.resp"}, model_resp(addr), b.resp);
    model_write(addr, data, strb);
  endtask

  task automatic read_check(input string name, input id_t id, input addr_t addr);
    axi_r_t r;
    axi_read(id, addr, r);
    check_value({name, " r.id"}, id, r.id);
    check_value({name, " r.data"}, model_read(addr), r.data);
    check_value({name, " r.resp"}, model_resp(addr), r.resp);
    check_value({name, " r.last"}, 1, r.last);
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_check("reset read", id_t'(i + 5), addr_t'(4 * i));
    end
  endtask

  task automatic test_write_read();
    write_check("full write", 4'h3, 32'h8, 32'hDEAD_BEEF, 4'hF);
    read_check("full read", 4'hC, 32'h8);
  endtask

  task automatic test_partial_strobes();
    write_check("strobe base", 4'h1, 32'h4, 32'h1122_3344, 4'hF);
    write_check("strobe 0101", 4'h2, 32'h4, 32'hAABB_CCDD, 4'b0101);
    read_check("strobe 0101 read", 4'h7, 32'h4);
    write_check("strobe 1000", 4'hE, 32'h4, 32'h5566_7788, 4'b1000);
    write_check("strobe 0010", 4'hF, 32'h4, 32'h99AA_BBCC, 4'b0010);
    read_check("strobe mixed read", 4'h8, 32'h4);
  endtask

  task automatic test_out_of_range();
    write_check("oor write", 4'h7, addr_t'(4 * NUM_REGS), 32'hFFFF_FFFF, 4'hF);
    write_check("oor write far", 4'h4, 32'h0000_0100, 32'h1234_5678, 4'hF);
    read_check("oor read", 4'h2, addr_t'(4 * NUM_REGS));
    for (int i = 0; i < NUM_REGS; i++) begin
      read_check("after oor", id_t'(i), addr_t'(4 * i));
    end
  endtask

  task automatic test_backpressure();
    int     waited;
    axi_b_t b_first;
    axi_r_t r_first;
    // Write side with a second write queued behind a stalled B
    @(posedge clk_i);
    drive_write(4'h5, 32'h10, 32'h0BAD_F00D, 4'hF);
    wait_high(WR_ACCEPT, "stalled write acceptance", waited);
    @(posedge clk_i);
    model_write(32'h10, 32'h0BAD_F00D, 4'hF);
    drive_write(4'hA, 32'h14, 32'h1234_5678, 4'hF);
    wait_high(B_VALID, "stalled write response", waited);
    check_value("bp b latency", 1, waited);
    b_first = s_b_o;
    check_value("bp b.id", 4'h5, b_first.id);
    repeat (4) begin
      @(negedge clk_i);
      check_value("bp b_valid held", 1, s_b_valid_o);
      check_value("bp b stable", b_first, s_b_o);
      check_value("bp aw_ready low", 0, s_aw_ready_o);
      check_value("bp w_ready low", 0, s_w_ready_o);
    end
    @(posedge clk_i);
    s_b_ready_i <= 1'b1;
    @(posedge clk_i);
    wait_high(WR_ACCEPT, "write after released B", waited);
    check_value("bp aw_ready return", 1, waited);
    @(posedge clk_i);
    model_write(32'h14, 32'h1234_5678, 4'hF);
    s_aw_valid_i <= 1'b0;
    s_w_valid_i  <= 1'b0;
    wait_high(B_VALID, "queued write response", waited);
    check_value("bp second b latency", 1, waited);
    check_value("bp second b.id", 4'hA, s_b_o.id);
    @(posedge clk_i);
    s_b_ready_i <= 1'b0;
    // Read side follows the same pattern
    s_ar_i       <= '{id: 4'h6, addr: 32'h10, len: '0, prot: '0};
    s_ar_valid_i <= 1'b1;
    wait_high(AR_ACCEPT, "stalled read acceptance", waited);
    @(posedge clk_i);
    s_ar_i <= '{id: 4'h9, addr: 32'h14, len: '0, prot: '0};
    wait_high(R_VALID, "stalled read response", waited);
    check_value("bp r latency", 1, waited);
    r_first = s_r_o;
    check_value("bp r.id", 4'h6, r_first.id);
    check_value("bp r.data", model_read(32'h10), r_first.data);
    repeat (4) begin
      @(negedge clk_i);
      check_value("bp r_valid held", 1, s_r_valid_o);
      check_value("bp r stable", r_first, s_r_o);
      check_value("bp ar_ready low", 0, s_ar_ready_o);
    end
    @(posedge clk_i);
    s_r_ready_i <= 1'b1;
    @(posedge clk_i);
    wait_high(AR_ACCEPT, "read after released R", waited);
    check_value("bp ar_ready return", 1, waited);
    @(posedge clk_i);
    s_ar_valid_i <= 1'b0;
    wait_high(R_VALID, "queued read response", waited);
    check_value("bp second r.id", 4'h9, s_r_o.id);
    check_value("bp second r.data", model_read(32'h14), s_r_o.data);
    @(posedge clk_i);
    s_r_ready_i <= 1'b0;
  endtask

  task automatic test_random();
    id_t   id;
    addr_t addr;
    for (int n = 0; n < RAND_TXNS; n++) begin
      id   = id_t'(rand_bits(4));
      addr = addr_t'(rand_bits($clog2(NUM_REGS))) << 2;
      if (rand_bits(1) == 1) begin
        write_check("random write", id, addr, rand_bits(32), strb_t'(rand_bits(4)));
      end else begin
        read_check("random read", id, addr);
      end
    end
  endtask

  initial begin
    rst_i        = 1'b1;
    s_aw_i       = '0;
    s_aw_valid_i = 1'b0;
    s_w_i        = '0;
    s_w_valid_i  = 1'b0;
    s_b_ready_i  = 1'b0;
    s_ar_i       = '0;
    s_ar_valid_i = 1'b0;
    s_r_ready_i  = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset_values();
    test_write_read();
    test_partial_strobes();
    test_out_of_range();
    test_backpressure();
    test_random();
    repeat (2) @(posedge clk_i);
    $display("Run complete after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/axi_conv_pkg.sv
verilog/id_reflect_fifo.sv
verilog/axi_write_reflect.sv
verilog/axi_read_reflect.sv
verilog/lite_reg_bank.sv
verilog/axi_to_lite_top.sv
test/axi_to_lite_tb.sv
